//--- design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and instruction field widths
`define CPU_XLEN      32
`define CPU_REG_W     5
`define CPU_OP_W      5
`define CPU_IMM_W     17
`define CPU_TARGET_W  27

// opcodes in ir[31:27]
`define OP_RTYPE      5'b00000
`define OP_J          5'b00001
`define OP_BNE        5'b00010
`define OP_ADDI       5'b00101
`define OP_BLT        5'b00110
`define OP_SW         5'b00111
`define OP_LW         5'b01000

// alu op field in ir[6:2]
`define ALU_ADD       5'd0
`define ALU_SUB       5'd1
`define ALU_AND       5'd2
`define ALU_OR        5'd3
`define ALU_SLL       5'd4
`define ALU_SRA       5'd5

// register 0 always reads as zero
`define CPU_ZERO_REG  5'd0

// first fetch address out of reset
`define CPU_RESET_PC  32'd0

`endif

//--- design/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    // data word, also used for pc and memory addresses
    typedef logic [`CPU_XLEN-1:0] word_t;

    // register number in rd, rs and rt fields
    typedef logic [`CPU_REG_W-1:0] reg_idx_t;

    // top five bits of every instruction
    typedef logic [`CPU_OP_W-1:0] opcode_t;

    // alu function select, same width as the opcode
    typedef logic [`CPU_OP_W-1:0] alu_op_t;

    // shift amount for sll and sra
    typedef logic [`CPU_REG_W-1:0] shamt_t;

    // where a decode operand comes from
    typedef logic [1:0] fwd_sel_t;

    // operand straight from the register file
    // (the writeback case is covered by regfile write-through)
    localparam fwd_sel_t FWD_RF   = 2'd0;

    // result of the instruction now in execute
    localparam fwd_sel_t FWD_EX   = 2'd1;

    // alu result of the instruction now in memory
    localparam fwd_sel_t FWD_MEM  = 2'd2;

    // data memory output for a lw in memory
    localparam fwd_sel_t FWD_LOAD = 2'd3;

endpackage

//--- design/alu.sv
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
    input  word_t   operand_a_i,
    input  word_t   operand_b_i,
    input  alu_op_t alu_op_i,
    input  shamt_t  shamt_i,
    output word_t   result_o,
    output logic    not_equal_o,
    output logic    less_than_o
);

    word_t sum;
    word_t diff;

    assign sum  = operand_a_i + operand_b_i;
    assign diff = operand_a_i - operand_b_i;

    always_comb begin
        case (alu_op_i)
            `ALU_ADD: result_o = sum;
            `ALU_SUB: result_o = diff;
            `ALU_AND: result_o = operand_a_i & operand_b_i;
            `ALU_OR:  result_o = operand_a_i | operand_b_i;
            // shifts use only operand a and shamt
            `ALU_SLL: result_o = operand_a_i << shamt_i;
            `ALU_SRA: result_o = $signed(operand_a_i) >>> shamt_i;
            default:  result_o = '0;
        endcase
    end

    // flags from the same subtract
    assign not_equal_o = (diff != '0);

    // signed compare, immune to subtract overflow
    assign less_than_o = ($signed(operand_a_i) < $signed(operand_b_i));

endmodule

//--- design/regfile.sv
module regfile (
    input  logic        clock,
    input  logic        reset_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    // r1 to r31, r0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clock) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is visible on the read ports
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 :
                       (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 :
                       (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs[raddr_b_i];

endmodule

//--- design/fetch_stage.sv
`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  reset_i,
    input  logic  stall_i,
    input  logic  branch_flush_i,
    input  word_t branch_target_i,
    input  word_t q_imem_i,
    output word_t address_imem_o,
    output word_t fd_pc_o,
    output word_t fd_ir_o
);

    word_t   pc;
    word_t   pc_plus_one;
    word_t   jump_target;
    opcode_t fetch_opcode;
    logic    is_jump;

    assign address_imem_o = pc;
    assign pc_plus_one    = pc + word_t'(1);

    // j is recognised on the word coming back from imem
    assign fetch_opcode = q_imem_i[31:27];
    assign is_jump      = (fetch_opcode == `OP_J);

    // target field is unsigned, upper bits forced to zero
    assign jump_target = {{(`CPU_XLEN-`CPU_TARGET_W){1'b0}}, q_imem_i[`CPU_TARGET_W-1:0]};

    always_ff @(posedge clock) begin
        if (reset_i) begin
            pc      <= `CPU_RESET_PC;
            fd_pc_o <= '0;
            fd_ir_o <= '0;
        end else if (branch_flush_i) begin
            // taken branch in execute wins over everything
            pc      <= branch_target_i;
            fd_pc_o <= '0;
            fd_ir_o <= '0;
        end else if (!stall_i) begin
            if (is_jump) begin
                // the j itself is dropped, one bubble
                pc      <= jump_target;
                fd_pc_o <= '0;
                fd_ir_o <= '0;
            end else begin
                pc      <= pc_plus_one;
                fd_pc_o <= pc;
                fd_ir_o <= q_imem_i;
            end
        end
        // load-use stall keeps pc and fd as they are
    end

endmodule

//--- design/hazard_unit.sv
`include "cpu_config.svh"

module hazard_unit import cpu_pkg::*; (
    input  word_t    fd_ir_i,
    input  word_t    dx_ir_i,
    input  word_t    xm_ir_i,
    output logic     stall_o,
    output fwd_sel_t fwd_a_o,
    output fwd_sel_t fwd_b_o
);

    opcode_t  fd_op;
    opcode_t  dx_op;
    opcode_t  xm_op;
    reg_idx_t fd_src_a;
    reg_idx_t fd_src_b;
    reg_idx_t dx_rd;
    reg_idx_t xm_rd;
    logic     fd_b_is_rd;
    logic     fd_uses_a;
    logic     fd_uses_b;
    logic     dx_writes;
    logic     xm_writes;
    logic     dx_is_lw;
    logic     xm_is_lw;
    logic     a_hit_dx;
    logic     b_hit_dx;
    logic     a_hit_xm;
    logic     b_hit_xm;

    // youngest writer first, load data if memory holds a lw
    function automatic fwd_sel_t pick_source(input logic hit_dx, input logic hit_xm,
                                             input logic from_load);
        fwd_sel_t sel;
        if (hit_dx) begin
            sel = FWD_EX;
        end else if (hit_xm) begin
            sel = from_load ? FWD_LOAD : FWD_MEM;
        end else begin
            sel = FWD_RF;
        end
        return sel;
    endfunction

    assign fd_op = fd_ir_i[31:27];
    assign dx_op = dx_ir_i[31:27];
    assign xm_op = xm_ir_i[31:27];
    assign dx_rd = dx_ir_i[26:22];
    assign xm_rd = xm_ir_i[26:22];

    // sw data and branch compare read rd on port b
    assign fd_b_is_rd = (fd_op == `OP_SW) || (fd_op == `OP_BNE) || (fd_op == `OP_BLT);
    assign fd_src_a   = fd_ir_i[21:17];
    assign fd_src_b   = fd_b_is_rd ? fd_ir_i[26:22] : fd_ir_i[16:12];

    // port b only matters for r-type, sw and branches
    assign fd_uses_a = (fd_op != `OP_J);
    assign fd_uses_b = (fd_op == `OP_RTYPE) || fd_b_is_rd;

    // r-type, addi and lw are the only register writers
    assign dx_is_lw  = (dx_op == `OP_LW);
    assign xm_is_lw  = (xm_op == `OP_LW);
    assign dx_writes = (dx_op == `OP_RTYPE) || (dx_op == `OP_ADDI) || dx_is_lw;
    assign xm_writes = (xm_op == `OP_RTYPE) || (xm_op == `OP_ADDI) || xm_is_lw;

    // register 0 never matches
    assign a_hit_dx = fd_uses_a && dx_writes && (dx_rd == fd_src_a) && (fd_src_a != `CPU_ZERO_REG);
    assign b_hit_dx = fd_uses_b && dx_writes && (dx_rd == fd_src_b) && (fd_src_b != `CPU_ZERO_REG);
    assign a_hit_xm = fd_uses_a && xm_writes && (xm_rd == fd_src_a) && (fd_src_a != `CPU_ZERO_REG);
    assign b_hit_xm = fd_uses_b && xm_writes && (xm_rd == fd_src_b) && (fd_src_b != `CPU_ZERO_REG);

    // load data is not ready until the lw reaches memory
    assign stall_o = dx_is_lw && (a_hit_dx || b_hit_dx);

    assign fwd_a_o = pick_source(a_hit_dx, a_hit_xm, xm_is_lw);
    assign fwd_b_o = pick_source(b_hit_dx, b_hit_xm, xm_is_lw);

endmodule

//--- design/decode_stage.sv
`include "cpu_config.svh"

module decode_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     branch_flush_i,
    input  word_t    fd_pc_i,
    input  word_t    fd_ir_i,
    input  fwd_sel_t fwd_a_i,
    input  fwd_sel_t fwd_b_i,
    input  word_t    ex_result_i,
    input  word_t    xm_o_i,
    input  word_t    q_dmem_i,
    output reg_idx_t rf_raddr_a_o,
    output reg_idx_t rf_raddr_b_o,
    input  word_t    rf_rdata_a_i,
    input  word_t    rf_rdata_b_i,
    output word_t    dx_pc_o,
    output word_t    dx_ir_o,
    output word_t    dx_a_o,
    output word_t    dx_b_o
);

    opcode_t  fd_op;
    reg_idx_t fd_rd;
    reg_idx_t fd_rs;
    reg_idx_t fd_rt;
    logic     b_reads_rd;
    word_t    operand_a;
    word_t    operand_b;

    // choose between regfile and the three in-flight results
    function automatic word_t bypass_mux(input fwd_sel_t sel, input word_t rf_val,
                                         input word_t ex_val, input word_t mem_val,
                                         input word_t load_val);
        word_t val;
        case (sel)
            FWD_EX:   val = ex_val;
            FWD_MEM:  val = mem_val;
            FWD_LOAD: val = load_val;
            default:  val = rf_val;
        endcase
        return val;
    endfunction

    // r-type field layout, i-type shares opcode rd rs
    assign fd_op = fd_ir_i[31:27];
    assign fd_rd = fd_ir_i[26:22];
    assign fd_rs = fd_ir_i[21:17];
    assign fd_rt = fd_ir_i[16:12];

    // port a is always rs
    // port b is rd for sw data and for branch compare, rt otherwise
    assign b_reads_rd   = (fd_op == `OP_SW) || (fd_op == `OP_BNE) || (fd_op == `OP_BLT);
    assign rf_raddr_a_o = fd_rs;
    assign rf_raddr_b_o = b_reads_rd ? fd_rd : fd_rt;

    assign operand_a = bypass_mux(fwd_a_i, rf_rdata_a_i, ex_result_i, xm_o_i, q_dmem_i);
    assign operand_b = bypass_mux(fwd_b_i, rf_rdata_b_i, ex_result_i, xm_o_i, q_dmem_i);

    always_ff @(posedge clock) begin
        if (reset_i || stall_i || branch_flush_i) begin
            // all-zero word is add r0,r0,r0
            dx_pc_o <= '0;
            dx_ir_o <= '0;
            dx_a_o  <= '0;
            dx_b_o  <= '0;
        end else begin
            dx_pc_o <= fd_pc_i;
            dx_ir_o <= fd_ir_i;
            dx_a_o  <= operand_a;
            dx_b_o  <= operand_b;
        end
    end

endmodule

//--- design/execute_stage.sv
`include "cpu_config.svh"

module execute_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  reset_i,
    input  word_t dx_pc_i,
    input  word_t dx_ir_i,
    input  word_t dx_a_i,
    input  word_t dx_b_i,
    output word_t ex_result_o,
    output logic  branch_flush_o,
    output word_t branch_target_o,
    output word_t xm_ir_o,
    output word_t xm_o_o,
    output word_t xm_b_o
);

    opcode_t dx_op;
    shamt_t  dx_shamt;
    alu_op_t dx_alu_op;
    alu_op_t main_op;
    word_t   dx_imm;
    word_t   main_b;
    logic    use_imm;
    logic    is_bne;
    logic    is_blt;
    logic    cmp_ne;
    logic    cmp_lt;

    assign dx_op     = dx_ir_i[31:27];
    assign dx_shamt  = dx_ir_i[11:7];
    assign dx_alu_op = dx_ir_i[6:2];

    // 17-bit immediate, sign extended
    assign dx_imm = {{(`CPU_XLEN-`CPU_IMM_W){dx_ir_i[`CPU_IMM_W-1]}}, dx_ir_i[`CPU_IMM_W-1:0]};

    // addi and address calculation add rs to the immediate
    assign use_imm = (dx_op == `OP_ADDI) || (dx_op == `OP_LW) || (dx_op == `OP_SW);
    assign main_b  = use_imm ? dx_imm : dx_b_i;
    assign main_op = use_imm ? `ALU_ADD : dx_alu_op;

    alu main_alu (
        .operand_a_i (dx_a_i),
        .operand_b_i (main_b),
        .alu_op_i    (main_op),
        .shamt_i     (dx_shamt),
        .result_o    (ex_result_o),
        .not_equal_o (),
        .less_than_o ()
    );

    // rd is on port b and rs on port a, so compare b against a
    alu branch_alu (
        .operand_a_i (dx_b_i),
        .operand_b_i (dx_a_i),
        .alu_op_i    (`ALU_SUB),
        .shamt_i     ('0),
        .result_o    (),
        .not_equal_o (cmp_ne),
        .less_than_o (cmp_lt)
    );

    assign is_bne = (dx_op == `OP_BNE);
    assign is_blt = (dx_op == `OP_BLT);

    // taken branch flushes fd and dx this cycle
    assign branch_flush_o  = (is_bne && cmp_ne) || (is_blt && cmp_lt);
    assign branch_target_o = dx_pc_i + word_t'(1) + dx_imm;

    // the branch itself moves on, it writes nothing downstream
    always_ff @(posedge clock) begin
        if (reset_i) begin
            xm_ir_o <= '0;
            xm_o_o  <= '0;
            xm_b_o  <= '0;
        end else begin
            xm_ir_o <= dx_ir_i;
            xm_o_o  <= ex_result_o;
            xm_b_o  <= dx_b_i;
        end
    end

endmodule

//--- design/writeback_stage.sv
`include "cpu_config.svh"

module writeback_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     reset_i,
    input  word_t    xm_ir_i,
    input  word_t    xm_o_i,
    input  word_t    q_dmem_i,
    output logic     rf_we_o,
    output reg_idx_t rf_waddr_o,
    output word_t    rf_wdata_o
);

    word_t   mw_ir;
    word_t   mw_o;
    word_t   mw_d;
    opcode_t mw_op;
    logic    mw_is_lw;
    logic    no_write;

    // mw register, load data captured at the end of the memory stage
    always_ff @(posedge clock) begin
        if (reset_i) begin
            mw_ir <= '0;
            mw_o  <= '0;
            mw_d  <= '0;
        end else begin
            mw_ir <= xm_ir_i;
            mw_o  <= xm_o_i;
            mw_d  <= q_dmem_i;
        end
    end

    assign mw_op    = mw_ir[31:27];
    assign mw_is_lw = (mw_op == `OP_LW);

    // stores, branches and jumps have no destination
    assign no_write = (mw_op == `OP_SW) || (mw_op == `OP_BNE) ||
                      (mw_op == `OP_BLT) || (mw_op == `OP_J);

    assign rf_we_o    = !no_write;
    assign rf_waddr_o = mw_ir[26:22];
    assign rf_wdata_o = mw_is_lw ? mw_d : mw_o;

endmodule

//--- design/processor.sv
`include "cpu_config.svh"

module processor import cpu_pkg::*; (
    input  logic  clock,
    input  logic  reset_i,
    output word_t address_imem_o,
    input  word_t q_imem_i,
    output word_t address_dmem_o,
    output word_t data_dmem_o,
    output logic  wren_dmem_o,
    input  word_t q_dmem_i
);

    // fd, dx and xm pipeline registers
    word_t    fd_pc;
    word_t    fd_ir;
    word_t    dx_pc;
    word_t    dx_ir;
    word_t    dx_a;
    word_t    dx_b;
    word_t    xm_ir;
    word_t    xm_o;
    word_t    xm_b;

    // control between stages
    word_t    ex_result;
    word_t    branch_target;
    logic     branch_flush;
    logic     stall;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    // register file ports
    reg_idx_t rf_raddr_a;
    reg_idx_t rf_raddr_b;
    word_t    rf_rdata_a;
    word_t    rf_rdata_b;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    fetch_stage fetch_i (
        .clock, .reset_i,
        .stall_i (stall), .branch_flush_i (branch_flush), .branch_target_i (branch_target),
        .q_imem_i, .address_imem_o,
        .fd_pc_o (fd_pc), .fd_ir_o (fd_ir)
    );

    hazard_unit hazard_i (
        .fd_ir_i (fd_ir), .dx_ir_i (dx_ir), .xm_ir_i (xm_ir),
        .stall_o (stall), .fwd_a_o (fwd_a), .fwd_b_o (fwd_b)
    );

    decode_stage decode_i (
        .clock, .reset_i,
        .stall_i (stall), .branch_flush_i (branch_flush),
        .fd_pc_i (fd_pc), .fd_ir_i (fd_ir),
        .fwd_a_i (fwd_a), .fwd_b_i (fwd_b),
        .ex_result_i (ex_result), .xm_o_i (xm_o), .q_dmem_i,
        .rf_raddr_a_o (rf_raddr_a), .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a), .rf_rdata_b_i (rf_rdata_b),
        .dx_pc_o (dx_pc), .dx_ir_o (dx_ir), .dx_a_o (dx_a), .dx_b_o (dx_b)
    );

    execute_stage execute_i (
        .clock, .reset_i,
        .dx_pc_i (dx_pc), .dx_ir_i (dx_ir), .dx_a_i (dx_a), .dx_b_i (dx_b),
        .ex_result_o (ex_result),
        .branch_flush_o (branch_flush), .branch_target_o (branch_target),
        .xm_ir_o (xm_ir), .xm_o_o (xm_o), .xm_b_o (xm_b)
    );

    writeback_stage writeback_i (
        .clock, .reset_i,
        .xm_ir_i (xm_ir), .xm_o_i (xm_o), .q_dmem_i,
        .rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata)
    );

    regfile regfile_i (
        .clock, .reset_i,
        .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata),
        .raddr_a_i (rf_raddr_a), .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a), .rdata_b_o (rf_rdata_b)
    );

    // memory stage is just the dmem ports off the xm register
    assign address_dmem_o = xm_o;
    assign data_dmem_o    = xm_b;
    assign wren_dmem_o    = (xm_ir[31:27] == `OP_SW);

endmodule

//--- tests/processor_tb.sv
module processor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS    = 256;
    localparam int MAX_STORES   = 32;
    localparam int CASE_CYCLES  = 200;
    localparam int DRAIN_CYCLES = 10;

    logic        clock;
    logic        reset_i;
    logic [31:0] address_imem_o;
    logic [31:0] q_imem_i;
    logic [31:0] address_dmem_o;
    logic [31:0] data_dmem_o;
    logic        wren_dmem_o;
    logic [31:0] q_dmem_i;

    // word-addressed memories indexed by the low 8 address bits
    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];

    // expected stores of the current case in program order
    logic [31:0] exp_addr [0:MAX_STORES-1];
    logic [31:0] exp_data [0:MAX_STORES-1];
    int          n_stores;
    int          n_instr;
    int          n_cases;
    int          fd;
    logic        found;
    logic [8*32-1:0] case_name;

    processor processor_i (
        .clock          (clock),
        .reset_i        (reset_i),
        .address_imem_o (address_imem_o),
        .q_imem_i       (q_imem_i),
        .address_dmem_o (address_dmem_o),
        .data_dmem_o    (data_dmem_o),
        .wren_dmem_o    (wren_dmem_o),
        .q_dmem_i       (q_dmem_i)
    );

    always #5 clock = ~clock;

    // both memories answer in the same cycle
    assign q_imem_i = imem[address_imem_o[7:0]];
    assign q_dmem_i = dmem[address_dmem_o[7:0]];

    // store lands on the rising edge
    always @(posedge clock) begin
        if (wren_dmem_o === 1'b1) begin
            dmem[address_dmem_o[7:0]] <= data_dmem_o;
        end
    end

    task automatic fail_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [8*16-1:0] what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %0s %0s: expected %h, actual %h", case_name, what, expected,
                     actual);
            fail_run();
        end
    endtask

    // rest of a comment line in the cases file
    task automatic skip_line();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // reads one case block up to its end token
    // got_case stays low at end of file
    task automatic read_case(output logic got_case);
        logic [8*16-1:0] tag;
        logic [31:0]     addr;
        logic [31:0]     word;
        logic            done;
        int              rc;
        got_case = 1'b0;
        done     = 1'b0;
        n_instr  = 0;
        n_stores = 0;
        // imem defaults to nops and dmem to an address-dependent pattern
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = 32'h0;
            dmem[a] = 32'hd5000000 + a * 32'h00010101;
        end
        while (!done) begin
            rc = $fscanf(fd, "%s", tag);
            if (rc != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                skip_line();
            end else if (tag == "case") begin
                rc = $fscanf(fd, "%s", case_name);
                got_case = 1'b1;
            end else if (tag == "i") begin
                rc = $fscanf(fd, "%h", word);
                imem[n_instr] = word;
                n_instr++;
            end else if (tag == "d") begin
                rc = $fscanf(fd, "%h %h", addr, word);
                dmem[addr[7:0]] = word;
            end else if (tag == "s") begin
                rc = $fscanf(fd, "%h %h", addr, word);
                exp_addr[n_stores] = addr;
                exp_data[n_stores] = word;
                n_stores++;
            end else if (tag == "end") begin
                done = 1'b1;
            end else begin
                $display("the cases file holds an unknown token %0s", tag);
                fail_run();
            end
        end
    endtask

    // compare every store with the list and then watch for stray ones
    task automatic run_case();
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n_stores) begin
            @(negedge clock);
            cycles++;
            if (wren_dmem_o !== 1'b0) begin
                check_value("store address", exp_addr[seen], address_dmem_o);
                check_value("store data", exp_data[seen], data_dmem_o);
                seen++;
            end else if (cycles >= CASE_CYCLES) begin
                $display("case %0s never made store %0d of %0d to address %h", case_name,
                         seen + 1, n_stores, exp_addr[seen]);
                fail_run();
            end
        end
        for (int k = 0; k < DRAIN_CYCLES; k++) begin
            @(negedge clock);
            if (wren_dmem_o !== 1'b0) begin
                $display("case %0s stored %h to address %h after its last expected store",
                         case_name, data_dmem_o, address_dmem_o);
                fail_run();
            end
        end
    endtask

    initial begin
        clock   = 1'b0;
        reset_i = 1'b1;
        n_cases = 0;
        found   = 1'b1;
        fd = $fopen("tests/processor_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/processor_cases.txt");
            fail_run();
        end
        while (found) begin
            reset_i = 1'b1;
            // memories are loaded while the pipeline sits in reset
            read_case(found);
            if (found) begin
                repeat (8) @(negedge clock);
                reset_i = 1'b0;
                run_case();
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("no case was read from the cases file");
            fail_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- processor.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/regfile.sv
design/fetch_stage.sv
design/hazard_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/processor.sv
tests/processor_tb.sv

//--- tests/processor_cases.txt
# tokens, all values hex: case <name> | i <instr> | d <addr> <data> | s <addr> <data> | end
# i fills imem from address 0, d presets dmem, s lists expected stores in the order they occur
case alu_bypass
i 28400005              # addi r1, r0, 5
i 2880000C              # addi r2, r0, 12
i 00C22000              # add  r3, r1, r2
i 38C00010 s 10 00000011  # sw r3, 16(r0)   r3 from execute
i 01022004              # sub  r4, r1, r2
i 01422008              # and  r5, r1, r2
i 0188500C              # or   r6, r4, r5
i 01CC0210              # sll  r7, r6, 4
i 020E0194              # sra  r8, r7, 3
i 39800013 s 13 FFFFFFFD  # sw r6, 19(r0)   r6 from writeback
i 3A000011 s 11 FFFFFFFA  # sw r8, 17(r0)   r8 from memory
i 39060003 s 14 FFFFFFF9  # sw r4, 3(r3)
i 3947FFFE s 0F 00000004  # sw r5, -2(r3)
i 39C00012 s 12 FFFFFFD0  # sw r7, 18(r0)
end
case load_use
d 20 0000ABCD d 21 00001234 d 22 00000007
i 40400020              # lw   r1, 32(r0)
i 28820001              # addi r2, r1, 1    stall
i 38800030 s 30 0000ABCE  # sw r2, 48(r0)
i 40C00021              # lw   r3, 33(r0)
i 38C00031 s 31 00001234  # sw r3, 49(r0)   stall, then load data
i 41000022              # lw   r4, 34(r0)
i 29860001              # addi r6, r3, 1
i 01486000              # add  r5, r4, r6   r4 from load data
i 39400032 s 32 0000123C  # sw r5, 50(r0)
end
case branches
i 28400003              # addi r1, r0, 3
i 2881FFFE              # addi r2, r0, -2
i 10420005              # bne  r1, r1, 5    not taken
i 38400040 s 40 00000003  # sw r1, 64(r0)
i 30820002              # blt  r2, r1, 2    taken
i 38800041              # sw   r2, 65(r0)   flushed
i 38800042              # sw   r2, 66(r0)   flushed
i 30440005              # blt  r1, r2, 5    not taken, signed
i 10440001              # bne  r1, r2, 1    taken
i 38400043              # sw   r1, 67(r0)   flushed
i 38800044 s 44 FFFFFFFE  # sw r2, 68(r0)
end
case jump_zero
i 08000003              # j 3
i 28400001              # addi r1, r0, 1    skipped
i 38400051              # sw   r1, 81(r0)   skipped
i 28000009              # addi r0, r0, 9    discarded
i 38000050 s 50 00000000  # sw r0, 80(r0)
i 38400052 s 52 00000000  # sw r1, 82(r0)   r1 still zero
end
